/* Makefile */
# Verilator build and run for the mxu testbench

VERILATOR ?= verilator
TOP       ?= mxu_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
SIM_ARGS  ?= +verilator+error+limit+1000

SRCS := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTS FAILED" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* build.f */
src/mxu_cfg_pkg.sv
src/mxu_bus_pkg.sv
src/mxu_pe.sv
src/mxu_ctrl_regs.sv
src/mxu_mem_engine.sv
src/mxu_operand_feeder.sv
src/mxu_result_drain.sv
src/mxu_top.sv
dv/mxu_tb_sva.sv
dv/mxu_tb.sv

/* dv/mxu_tb.sv */
`timescale 1ns/100ps

module mxu_tb
  import mxu_cfg_pkg::*;
  import mxu_bus_pkg::*;
();

  localparam int TIMEOUT      = 2000;
  localparam int RESET_CYCLES = 16;
  localparam int MEM_WORDS    = 256;
  localparam logic [31:0] A_BASE = 32'h0000_0100;
  localparam logic [31:0] B_BASE = 32'h0000_0200;
  localparam logic [31:0] C_BASE = 32'h0000_0300;

  logic        ap_clk = 1'b0;
  logic        ap_rst_n = 1'b0;
  logic        ctl_req_valid_i = 1'b0;
  ctl_req_t    ctl_req_i = '0;
  logic        ctl_req_ready_o;
  logic        ctl_rvalid_o;
  logic [31:0] ctl_rdata_o;
  logic        ctl_rready_i = 1'b0;
  logic        mem_ar_valid_o;
  mem_addr_t   mem_ar_o;
  logic        mem_ar_ready_i = 1'b0;
  logic        mem_r_valid_i = 1'b0;
  mem_rdata_t  mem_r_i = '0;
  logic        mem_r_ready_o;
  logic        mem_aw_valid_o;
  mem_addr_t   mem_aw_o;
  logic        mem_aw_ready_i = 1'b0;
  logic        mem_w_valid_o;
  mem_wdata_t  mem_w_o;
  logic        mem_w_ready_i = 1'b0;
  logic        mem_b_valid_i = 1'b0;
  logic        mem_b_ready_o;

  int          seed = 32'hbaf2_2631;
  int          rst_cycles = 0;
  int          err_cnt = 0;
  int          test_cnt = 0;
  int          failed_tests = 0;
  logic [31:0] mem [MEM_WORDS];
  int          c_ref [WR_BEATS];
  // memory model bookkeeping
  mem_addr_t   ar_log [$];
  mem_addr_t   aw_log [$];
  mem_wdata_t  w_log [$];
  logic [7:0]  rd_word;
  logic [7:0]  wr_word;
  int          rd_left = 0;
  logic        b_owed = 1'b0;

  mxu_top mxu_top_inst (.*);

  always #5 ap_clk = ~ap_clk;

  always @(posedge ap_clk) begin
    if (rst_cycles < RESET_CYCLES) begin
      rst_cycles <= rst_cycles + 1;
      ap_rst_n   <= 1'b0;
    end else begin
      ap_rst_n <= 1'b1;
    end
  end

  // one in four cycles stalls
  function automatic logic stall_now();
    return ($random(seed) & 3) == 0;
  endfunction

  // memory model, answers all five channels
  always @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      mem_ar_ready_i <= 1'b0;
      mem_r_valid_i  <= 1'b0;
      mem_aw_ready_i <= 1'b0;
      mem_w_ready_i  <= 1'b0;
      mem_b_valid_i  <= 1'b0;
      ctl_rready_i   <= 1'b0;
      rd_left = 0;
      b_owed  = 1'b0;
    end else begin
      // beat taken, step to the next word
      if (mem_r_valid_i && mem_r_ready_o) begin
        rd_word = rd_word + 1'b1;
        rd_left = rd_left - 1;
      end
      if (mem_ar_valid_o && mem_ar_ready_i) begin
        ar_log.push_back(mem_ar_o);
        rd_word = mem_ar_o.addr[9:2];
        rd_left = int'(mem_ar_o.len) + 1;
      end
      // stalled beat keeps its payload
      if (!(mem_r_valid_i && !mem_r_ready_o)) begin
        if (rd_left > 0 && !stall_now()) begin
          mem_r_valid_i <= 1'b1;
          mem_r_i       <= '{data: mem[rd_word], last: (rd_left == 1)};
        end else begin
          mem_r_valid_i <= 1'b0;
        end
      end
      if (mem_aw_valid_o && mem_aw_ready_i) begin
        aw_log.push_back(mem_aw_o);
        wr_word = mem_aw_o.addr[9:2];
      end
      if (mem_w_valid_o && mem_w_ready_i) begin
        w_log.push_back(mem_w_o);
        mem[wr_word] = mem_w_o.data;
        wr_word = wr_word + 1'b1;
        if (mem_w_o.last) b_owed = 1'b1;
      end
      // one response per write burst
      if (mem_b_valid_i && mem_b_ready_o) begin
        mem_b_valid_i <= 1'b0;
      end else if (!mem_b_valid_i && b_owed && !stall_now()) begin
        mem_b_valid_i <= 1'b1;
        b_owed = 1'b0;
      end
      mem_ar_ready_i <= !stall_now();
      mem_aw_ready_i <= !stall_now();
      mem_w_ready_i  <= !stall_now();
      ctl_rready_i   <= !stall_now();
    end
  end

  task automatic give_up(input string what);
    $display("timed out waiting for %s", what);
    $display("TESTS FAILED");
    $finish;
  endtask

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error: %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  // request stays up until the handshake edge
  task automatic send_request(input logic wr, input logic [7:0] addr, input logic [31:0] data);
    int t;
    ctl_req_valid_i <= 1'b1;
    ctl_req_i       <= '{write: wr, addr: addr, wdata: data};
    t = 0;
    do begin
      @(posedge ap_clk);
      t++;
    end while (!ctl_req_ready_o && t < TIMEOUT);
    if (!ctl_req_ready_o) give_up("control request handshake");
    else ctl_req_valid_i <= 1'b0;
  endtask

  task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
    int t;
    send_request(1'b0, addr, '0);
    t = 0;
    do begin
      @(posedge ap_clk);
      t++;
    end while (!(ctl_rvalid_o && ctl_rready_i) && t < TIMEOUT);
    data = ctl_rdata_o;
    if (!(ctl_rvalid_o && ctl_rready_i)) give_up("control read response");
  endtask

  task automatic wait_job_done();
    logic [31:0] st;
    int t;
    t = 0;
    do begin
      reg_read(REG_CTRL_STATUS, st);
      t++;
    end while (!st[0] && t < TIMEOUT);
    if (!st[0]) give_up("job completion");
  endtask

  // fresh operands, C = A x B as plain integers
  task automatic load_operands();
    int av;
    int bv;
    int acc;
    for (int w = 0; w < MEM_WORDS; w++) mem[w] = 32'hc0de_0000 ^ w;
    for (int r = 0; r < ARRAY_N; r++) begin
      mem[A_BASE[9:2] + r] = $random(seed);
      mem[B_BASE[9:2] + r] = $random(seed);
    end
    for (int i = 0; i < ARRAY_N; i++) begin
      for (int j = 0; j < ARRAY_N; j++) begin
        acc = 0;
        for (int k = 0; k < ARRAY_N; k++) begin
          // row is one word, element 0 in the low byte
          av  = $signed(mem[A_BASE[9:2] + i][8*k +: 8]);
          bv  = $signed(mem[B_BASE[9:2] + k][8*j +: 8]);
          acc = acc + av * bv;
        end
        c_ref[i*ARRAY_N + j] = acc;
      end
    end
    ar_log.delete();
    aw_log.delete();
    w_log.delete();
  endtask

  task automatic check_job();
    expect_equal("read request count", ar_log.size(), 2);
    if (ar_log.size() == 2) begin
      expect_equal("mem_ar_o.addr first", ar_log[0].addr, A_BASE);
      expect_equal("mem_ar_o.len first", ar_log[0].len, RD_BEATS - 1);
      expect_equal("mem_ar_o.addr second", ar_log[1].addr, B_BASE);
      expect_equal("mem_ar_o.len second", ar_log[1].len, RD_BEATS - 1);
    end
    expect_equal("write request count", aw_log.size(), 1);
    if (aw_log.size() == 1) begin
      expect_equal("mem_aw_o.addr", aw_log[0].addr, C_BASE);
      expect_equal("mem_aw_o.len", aw_log[0].len, WR_BEATS - 1);
    end
    expect_equal("write beat count", w_log.size(), WR_BEATS);
    // row-major, C[0][0] first
    for (int n = 0; n < w_log.size() && n < WR_BEATS; n++) begin
      expect_equal($sformatf("mem_w_o.data beat %0d", n), w_log[n].data, c_ref[n]);
      expect_equal($sformatf("mem_w_o.last beat %0d", n), w_log[n].last, n == WR_BEATS - 1);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      failed_tests++;
      $display("test %0d %s: failed", test_cnt, name);
    end
  endtask

  initial begin : main
    logic [31:0] rd;
    int          errs_before;
    int          t;
    t = 0;
    while (!ap_rst_n && t < TIMEOUT) begin
      @(posedge ap_clk);
      t++;
    end
    if (!ap_rst_n) give_up("reset release");

    errs_before = err_cnt;
    send_request(1'b1, REG_A_BASE, A_BASE);
    send_request(1'b1, REG_B_BASE, B_BASE);
    send_request(1'b1, REG_C_BASE, C_BASE);
    reg_read(REG_A_BASE, rd);
    expect_equal("ctl_rdata_o a_base", rd, A_BASE);
    reg_read(REG_B_BASE, rd);
    expect_equal("ctl_rdata_o b_base", rd, B_BASE);
    reg_read(REG_C_BASE, rd);
    expect_equal("ctl_rdata_o c_base", rd, C_BASE);
    reg_read(8'h44, rd);
    expect_equal("ctl_rdata_o unmapped", rd, REG_UNMAPPED_VALUE);
    finish_test("register readback", errs_before);

    // second start lands mid-job and must be dropped
    errs_before = err_cnt;
    load_operands();
    send_request(1'b1, REG_CTRL_STATUS, 32'h1);
    reg_read(REG_CTRL_STATUS, rd);
    expect_equal("ctl_rdata_o status after start", rd & 32'h3, 32'h2);
    send_request(1'b1, REG_CTRL_STATUS, 32'h1);
    wait_job_done();
    reg_read(REG_CTRL_STATUS, rd);
    expect_equal("ctl_rdata_o status after job", rd & 32'h3, 32'h1);
    check_job();
    finish_test("job with extra start while busy", errs_before);

    // done from the last job clears on the new start
    errs_before = err_cnt;
    load_operands();
    send_request(1'b1, REG_CTRL_STATUS, 32'h1);
    reg_read(REG_CTRL_STATUS, rd);
    expect_equal("ctl_rdata_o status after restart", rd & 32'h3, 32'h2);
    wait_job_done();
    reg_read(REG_CTRL_STATUS, rd);
    expect_equal("ctl_rdata_o status after second job", rd & 32'h3, 32'h1);
    check_job();
    finish_test("second job after done", errs_before);

    $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
             test_cnt, failed_tests, err_cnt, mxu_top_inst.sva_inst.fail_cnt);
    if (err_cnt == 0 && mxu_top_inst.sva_inst.fail_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* dv/mxu_tb_sva.sv */
`timescale 1ns/100ps

module mxu_tb_sva
  import mxu_cfg_pkg::*;
  import mxu_bus_pkg::*;
(
  input logic        ap_clk,
  input logic        ap_rst_n,
  input logic        ctl_rvalid_o,
  input logic [31:0] ctl_rdata_o,
  input logic        ctl_rready_i,
  input logic        mem_ar_valid_o,
  input mem_addr_t   mem_ar_o,
  input logic        mem_ar_ready_i,
  input logic        mem_r_valid_i,
  input mem_rdata_t  mem_r_i,
  input logic        mem_r_ready_o,
  input logic        mem_aw_valid_o,
  input mem_addr_t   mem_aw_o,
  input logic        mem_aw_ready_i,
  input logic        mem_w_valid_o,
  input mem_wdata_t  mem_w_o,
  input logic        mem_w_ready_i,
  input logic        mem_b_valid_i,
  input logic        mem_b_ready_o
);

  // read by the testbench at the end of the run
  int fail_cnt = 0;

  // address channels hold until accepted
  ar_hold: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    mem_ar_valid_o && !mem_ar_ready_i |=> mem_ar_valid_o && $stable(mem_ar_o))
    else begin $error("read address dropped or changed before handshake"); fail_cnt++; end

  aw_hold: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    mem_aw_valid_o && !mem_aw_ready_i |=> mem_aw_valid_o && $stable(mem_aw_o))
    else begin $error("write address dropped or changed before handshake"); fail_cnt++; end

  // write beats under back-pressure
  w_hold: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    mem_w_valid_o && !mem_w_ready_i |=> mem_w_valid_o && $stable(mem_w_o))
    else begin $error("write beat dropped or changed before handshake"); fail_cnt++; end

  // memory model side, same rule
  r_hold: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    mem_r_valid_i && !mem_r_ready_o |=> mem_r_valid_i && $stable(mem_r_i))
    else begin $error("read beat dropped or changed before handshake"); fail_cnt++; end

  b_hold: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    mem_b_valid_i && !mem_b_ready_o |=> mem_b_valid_i)
    else begin $error("write response dropped before handshake"); fail_cnt++; end

  // register read response held until taken
  ctl_hold: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    ctl_rvalid_o && !ctl_rready_i |=> ctl_rvalid_o && $stable(ctl_rdata_o))
    else begin $error("register read response dropped or changed"); fail_cnt++; end

  // results only leave after both operands are in
  w_after_reads: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    mem_w_valid_o |-> !mem_r_ready_o && !mem_ar_valid_o)
    else begin $error("write data overlaps the operand reads"); fail_cnt++; end

endmodule

bind mxu_top mxu_tb_sva sva_inst (
  .ap_clk, .ap_rst_n,
  .ctl_rvalid_o, .ctl_rdata_o, .ctl_rready_i,
  .mem_ar_valid_o, .mem_ar_o, .mem_ar_ready_i,
  .mem_r_valid_i, .mem_r_i, .mem_r_ready_o,
  .mem_aw_valid_o, .mem_aw_o, .mem_aw_ready_i,
  .mem_w_valid_o, .mem_w_o, .mem_w_ready_i,
  .mem_b_valid_i, .mem_b_ready_o
);

/* src/mxu_bus_pkg.sv */
package mxu_bus_pkg;

  import mxu_cfg_pkg::*;

  // control register map, byte offsets
  // bit 0 write = start, read = {busy, done}
  localparam logic [7:0] REG_CTRL_STATUS = 8'h00;
  localparam logic [7:0] REG_A_BASE      = 8'h10;
  localparam logic [7:0] REG_B_BASE      = 8'h14;
  localparam logic [7:0] REG_C_BASE      = 8'h18;

  // readback for holes in the map
  localparam logic [31:0] REG_UNMAPPED_VALUE = 32'hDEAD_BEEF;

  // host request, write or read
  typedef struct packed {
    logic        write;
    logic [7:0]  addr;
    logic [31:0] wdata;
  } ctl_req_t;

  // burst request, shared by read and write address channels
  // len is beats minus one
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
  } mem_addr_t;

  // read beat from memory
  typedef struct packed {
    logic [BEAT_W-1:0] data;
    logic              last;
  } mem_rdata_t;

  // write beat to memory
  typedef struct packed {
    logic [BEAT_W-1:0] data;
    logic              last;
  } mem_wdata_t;

endpackage

/* src/mxu_cfg_pkg.sv */
package mxu_cfg_pkg;

  // systolic grid side, square
  localparam int ARRAY_N = 4;

  // int8 operands, 32-bit sums
  localparam int ELEM_W = 8;
  localparam int ACC_W  = 32;

  // one memory beat carries one row of elements
  localparam int BEAT_W = ARRAY_N * ELEM_W;
  localparam int ADDR_W = 32;

  // operand bursts are one beat per row
  localparam int RD_BEATS = ARRAY_N;
  // result burst is one 32-bit sum per beat
  localparam int WR_BEATS = ARRAY_N * ARRAY_N;

  // feed start to capture
  // skew of 2N-2, N products per PE, plus register hops
  localparam int COMPUTE_CYCLES = 3 * ARRAY_N;

  typedef logic signed [ELEM_W-1:0] elem_t;
  typedef logic signed [ACC_W-1:0]  acc_t;

  // element 0 sits in the low byte
  typedef elem_t [ARRAY_N-1:0] row_t;

endpackage

/* src/mxu_ctrl_regs.sv */
`timescale 1ns/100ps

module mxu_ctrl_regs
  import mxu_cfg_pkg::*;
  import mxu_bus_pkg::*;
(
  input  logic              ap_clk,
  input  logic              ap_rst_n,
  input  logic              ctl_req_valid_i,
  input  ctl_req_t          ctl_req_i,
  output logic              ctl_req_ready_o,
  output logic              ctl_rvalid_o,
  output logic [31:0]       ctl_rdata_o,
  input  logic              ctl_rready_i,
  input  logic              busy_i,
  input  logic              job_done_i,
  output logic              start_o,
  output logic [ADDR_W-1:0] a_base_o,
  output logic [ADDR_W-1:0] b_base_o,
  output logic [ADDR_W-1:0] c_base_o
);

  logic req_hs;
  logic start_wr;
  logic busy_any;
  logic done_q;

  // one read response outstanding at most
  assign ctl_req_ready_o = !ctl_rvalid_o;
  assign req_hs          = ctl_req_valid_i && ctl_req_ready_o;

  // engine goes busy one cycle after the pulse, so count the pulse as busy too
  assign busy_any = busy_i || start_o;
  assign start_wr = req_hs && ctl_req_i.write && (ctl_req_i.addr == REG_CTRL_STATUS)
                    && ctl_req_i.wdata[0] && !busy_any;

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      start_o      <= 1'b0;
      done_q       <= 1'b0;
      ctl_rvalid_o <= 1'b0;
      a_base_o     <= '0;
      b_base_o     <= '0;
      c_base_o     <= '0;
    end else begin
      start_o <= start_wr;
      // sticky done, a new start wins over completion
      if (start_wr) begin
        done_q <= 1'b0;
      end else if (job_done_i) begin
        done_q <= 1'b1;
      end
      if (req_hs && ctl_req_i.write) begin
        case (ctl_req_i.addr)
          REG_A_BASE: a_base_o <= ctl_req_i.wdata;
          REG_B_BASE: b_base_o <= ctl_req_i.wdata;
          REG_C_BASE: c_base_o <= ctl_req_i.wdata;
          default: ;
        endcase
      end
      // read response held until taken
      if (req_hs && !ctl_req_i.write) begin
        ctl_rvalid_o <= 1'b1;
      end else if (ctl_rready_i) begin
        ctl_rvalid_o <= 1'b0;
      end
    end
  end

  // read data, loaded at the request handshake
  always_ff @(posedge ap_clk) begin
    if (req_hs && !ctl_req_i.write) begin
      case (ctl_req_i.addr)
        REG_CTRL_STATUS: ctl_rdata_o <= {30'd0, busy_any, done_q};
        REG_A_BASE:      ctl_rdata_o <= a_base_o;
        REG_B_BASE:      ctl_rdata_o <= b_base_o;
        REG_C_BASE:      ctl_rdata_o <= c_base_o;
        default:         ctl_rdata_o <= REG_UNMAPPED_VALUE;
      endcase
    end
  end

endmodule

/* src/mxu_mem_engine.sv */
`timescale 1ns/100ps

module mxu_mem_engine
  import mxu_cfg_pkg::*;
  import mxu_bus_pkg::*;
(
  input  logic              ap_clk,
  input  logic              ap_rst_n,
  input  logic              start_i,
  input  logic [ADDR_W-1:0] a_base_i,
  input  logic [ADDR_W-1:0] b_base_i,
  input  logic [ADDR_W-1:0] c_base_i,
  output logic              busy_o,
  output logic              job_done_o,
  output logic              mem_ar_valid_o,
  output mem_addr_t         mem_ar_o,
  input  logic              mem_ar_ready_i,
  input  logic              mem_r_valid_i,
  input  mem_rdata_t        mem_r_i,
  output logic              mem_r_ready_o,
  output logic              mem_aw_valid_o,
  output mem_addr_t         mem_aw_o,
  input  logic              mem_aw_ready_i,
  input  logic              mem_b_valid_i,
  output logic              mem_b_ready_o,
  output logic              beat_strobe_o,
  output logic              beat_is_b_o,
  output row_t              beat_row_o,
  output logic              feed_start_o,
  input  logic              results_ready_i,
  output logic              wr_go_o
);

  typedef enum logic [3:0] {
    S_IDLE,
    S_A_ADDR,
    S_A_DATA,
    S_B_ADDR,
    S_B_DATA,
    S_COMPUTE,
    S_W_ADDR,
    S_W_DATA,
    S_RESP
  } state_t;

  state_t            state_q;
  state_t            state_d;
  logic [ADDR_W-1:0] a_base_q;
  logic [ADDR_W-1:0] b_base_q;
  logic [ADDR_W-1:0] c_base_q;
  logic              r_last_hs;
  logic              b_hs;

  // read address, A then B, fixed burst length
  assign mem_ar_valid_o = (state_q == S_A_ADDR) || (state_q == S_B_ADDR);
  assign mem_ar_o       = '{addr: (state_q == S_B_ADDR) ? b_base_q : a_base_q,
                            len:  8'(RD_BEATS - 1)};

  // read beats go straight to the feeder
  assign mem_r_ready_o = (state_q == S_A_DATA) || (state_q == S_B_DATA);
  assign beat_strobe_o = mem_r_valid_i && mem_r_ready_o;
  assign beat_is_b_o   = (state_q == S_B_DATA);
  assign beat_row_o    = row_t'(mem_r_i.data);
  // phase ends on last, no beat count here
  assign r_last_hs     = beat_strobe_o && mem_r_i.last;

  // single result burst to C
  assign mem_aw_valid_o = (state_q == S_W_ADDR);
  assign mem_aw_o       = '{addr: c_base_q, len: 8'(WR_BEATS - 1)};
  assign wr_go_o        = mem_aw_valid_o && mem_aw_ready_i;

  assign mem_b_ready_o = (state_q == S_RESP);
  assign b_hs          = mem_b_valid_i && mem_b_ready_o;
  assign busy_o        = (state_q != S_IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:    if (start_i) state_d = S_A_ADDR;
      S_A_ADDR:  if (mem_ar_ready_i) state_d = S_A_DATA;
      S_A_DATA:  if (r_last_hs) state_d = S_B_ADDR;
      S_B_ADDR:  if (mem_ar_ready_i) state_d = S_B_DATA;
      S_B_DATA:  if (r_last_hs) state_d = S_COMPUTE;
      // drain raises ready once sums are snapped
      S_COMPUTE: if (results_ready_i) state_d = S_W_ADDR;
      S_W_ADDR:  if (mem_aw_ready_i) state_d = S_W_DATA;
      // drain drops ready after its last beat
      S_W_DATA:  if (!results_ready_i) state_d = S_RESP;
      S_RESP:    if (mem_b_valid_i) state_d = S_IDLE;
      default:   state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      state_q      <= S_IDLE;
      feed_start_o <= 1'b0;
      job_done_o   <= 1'b0;
    end else begin
      state_q      <= state_d;
      feed_start_o <= r_last_hs && beat_is_b_o;
      job_done_o   <= b_hs;
    end
  end

  // bases frozen for the whole job
  always_ff @(posedge ap_clk) begin
    if (start_i && (state_q == S_IDLE)) begin
      a_base_q <= a_base_i;
      b_base_q <= b_base_i;
      c_base_q <= c_base_i;
    end
  end

endmodule

/* src/mxu_operand_feeder.sv */
`timescale 1ns/100ps

module mxu_operand_feeder
  import mxu_cfg_pkg::*;
(
  input  logic               ap_clk,
  input  logic               ap_rst_n,
  input  logic               beat_strobe_i,
  input  logic               beat_is_b_i,
  input  row_t               beat_row_i,
  input  logic               feed_start_i,
  output row_t               west_elem_o,
  output logic [ARRAY_N-1:0] west_valid_o,
  output row_t               north_elem_o,
  output logic [ARRAY_N-1:0] north_valid_o,
  output logic               acc_clear_o,
  output logic               capture_o
);

  row_t                                   a_mem [ARRAY_N];
  row_t                                   b_mem [ARRAY_N];
  logic [$clog2(ARRAY_N)-1:0]             wr_ptr_q;
  logic [$clog2(COMPUTE_CYCLES+1)-1:0]    cnt_q;
  logic                                   run_q;

  // operand rows in arrival order, pointer wraps from A into B
  always_ff @(posedge ap_clk) begin
    if (beat_strobe_i && !beat_is_b_i) a_mem[wr_ptr_q] <= beat_row_i;
    if (beat_strobe_i && beat_is_b_i) b_mem[wr_ptr_q] <= beat_row_i;
  end

  // cnt is cycles since feed start, step is cnt minus one
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      wr_ptr_q <= '0;
      cnt_q    <= '0;
      run_q    <= 1'b0;
    end else begin
      if (feed_start_i) begin
        wr_ptr_q <= '0;
      end else if (beat_strobe_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (feed_start_i) begin
        run_q <= 1'b1;
        cnt_q <= 1;
      end else if (capture_o) begin
        run_q <= 1'b0;
      end else if (run_q) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // grid is idle before the first wavefront
  assign acc_clear_o = feed_start_i;
  assign capture_o   = run_q && (cnt_q == COMPUTE_CYCLES);

  // skewed wavefronts
  // row i gets A[i][t-i], column j gets B[t-j][j]
  always_comb begin
    int k;
    for (int n = 0; n < ARRAY_N; n++) begin
      k                = int'(cnt_q) - 1 - n;
      west_valid_o[n]  = run_q && (k >= 0) && (k < ARRAY_N);
      north_valid_o[n] = west_valid_o[n];
      west_elem_o[n]   = west_valid_o[n] ? a_mem[n][k[$clog2(ARRAY_N)-1:0]] : '0;
      north_elem_o[n]  = north_valid_o[n] ? b_mem[k[$clog2(ARRAY_N)-1:0]][n] : '0;
    end
  end

endmodule

/* src/mxu_pe.sv */
`timescale 1ns/100ps

module mxu_pe
  import mxu_cfg_pkg::*;
(
  input  logic  ap_clk,
  input  logic  ap_rst_n,
  input  logic  acc_clear_i,
  input  elem_t west_elem_i,
  input  logic  west_valid_i,
  input  elem_t north_elem_i,
  input  logic  north_valid_i,
  output elem_t east_elem_o,
  output logic  east_valid_o,
  output elem_t south_elem_o,
  output logic  south_valid_o,
  output acc_t  acc_o
);

  acc_t prod;

  // sign extend first, full 32-bit product
  assign prod = acc_t'(west_elem_i) * acc_t'(north_elem_i);

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      east_valid_o  <= 1'b0;
      south_valid_o <= 1'b0;
      acc_o         <= '0;
    end else begin
      east_valid_o  <= west_valid_i;
      south_valid_o <= north_valid_i;
      if (acc_clear_i) begin
        acc_o <= '0;
      end else if (west_valid_i && north_valid_i) begin
        acc_o <= acc_o + prod;
      end
    end
  end

  // operands hop one PE per cycle
  always_ff @(posedge ap_clk) begin
    east_elem_o  <= west_elem_i;
    south_elem_o <= north_elem_i;
  end

endmodule

/* src/mxu_result_drain.sv */
`timescale 1ns/100ps

module mxu_result_drain
  import mxu_cfg_pkg::*;
  import mxu_bus_pkg::*;
(
  input  logic                ap_clk,
  input  logic                ap_rst_n,
  input  logic                capture_i,
  input  acc_t [WR_BEATS-1:0] acc_i,
  output logic                results_ready_o,
  input  logic                wr_go_i,
  output logic                mem_w_valid_o,
  output mem_wdata_t          mem_w_o,
  input  logic                mem_w_ready_i
);

  acc_t [WR_BEATS-1:0]         snap_q;
  logic [$clog2(WR_BEATS)-1:0] idx_q;
  logic                        idx_last;

  // index is row-major, i*N+j
  assign idx_last = (idx_q == $bits(idx_q)'(WR_BEATS - 1));
  assign mem_w_o  = '{data: snap_q[idx_q], last: idx_last};

  // snapshot frees the grid for the next job
  always_ff @(posedge ap_clk) begin
    if (capture_i) snap_q <= acc_i;
  end

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      results_ready_o <= 1'b0;
      mem_w_valid_o   <= 1'b0;
      idx_q           <= '0;
    end else begin
      if (capture_i) results_ready_o <= 1'b1;
      if (wr_go_i) begin
        mem_w_valid_o <= 1'b1;
        idx_q         <= '0;
      end else if (mem_w_valid_o && mem_w_ready_i) begin
        // one element per accepted beat
        if (idx_last) begin
          mem_w_valid_o   <= 1'b0;
          results_ready_o <= 1'b0;
        end else begin
          idx_q <= idx_q + 1'b1;
        end
      end
    end
  end

endmodule

/* src/mxu_top.sv */
`timescale 1ns/100ps

module mxu_top
  import mxu_cfg_pkg::*;
  import mxu_bus_pkg::*;
(
  input  logic        ap_clk,
  input  logic        ap_rst_n,
  input  logic        ctl_req_valid_i,
  input  ctl_req_t    ctl_req_i,
  output logic        ctl_req_ready_o,
  output logic        ctl_rvalid_o,
  output logic [31:0] ctl_rdata_o,
  input  logic        ctl_rready_i,
  output logic        mem_ar_valid_o,
  output mem_addr_t   mem_ar_o,
  input  logic        mem_ar_ready_i,
  input  logic        mem_r_valid_i,
  input  mem_rdata_t  mem_r_i,
  output logic        mem_r_ready_o,
  output logic        mem_aw_valid_o,
  output mem_addr_t   mem_aw_o,
  input  logic        mem_aw_ready_i,
  output logic        mem_w_valid_o,
  output mem_wdata_t  mem_w_o,
  input  logic        mem_w_ready_i,
  input  logic        mem_b_valid_i,
  output logic        mem_b_ready_o
);

  logic                start;
  logic                busy;
  logic                job_done;
  logic [ADDR_W-1:0]   a_base;
  logic [ADDR_W-1:0]   b_base;
  logic [ADDR_W-1:0]   c_base;
  logic                beat_strobe;
  logic                beat_is_b;
  row_t                beat_row;
  logic                feed_start;
  logic                results_ready;
  logic                wr_go;
  row_t                west_elem;
  logic [ARRAY_N-1:0]  west_valid;
  row_t                north_elem;
  logic [ARRAY_N-1:0]  north_valid;
  logic                acc_clear;
  logic                capture;
  acc_t [WR_BEATS-1:0] acc_all;

  // grid links, h runs west to east, v runs north to south
  elem_t h_elem  [ARRAY_N][ARRAY_N+1];
  logic  h_valid [ARRAY_N][ARRAY_N+1];
  elem_t v_elem  [ARRAY_N+1][ARRAY_N];
  logic  v_valid [ARRAY_N+1][ARRAY_N];

  mxu_ctrl_regs ctrl_regs_inst (
    .ap_clk, .ap_rst_n, .ctl_req_valid_i, .ctl_req_i, .ctl_req_ready_o,
    .ctl_rvalid_o, .ctl_rdata_o, .ctl_rready_i,
    .busy_i(busy), .job_done_i(job_done), .start_o(start),
    .a_base_o(a_base), .b_base_o(b_base), .c_base_o(c_base)
  );

  mxu_mem_engine mem_engine_inst (
    .ap_clk, .ap_rst_n, .start_i(start),
    .a_base_i(a_base), .b_base_i(b_base), .c_base_i(c_base),
    .busy_o(busy), .job_done_o(job_done),
    .mem_ar_valid_o, .mem_ar_o, .mem_ar_ready_i,
    .mem_r_valid_i, .mem_r_i, .mem_r_ready_o,
    .mem_aw_valid_o, .mem_aw_o, .mem_aw_ready_i,
    .mem_b_valid_i, .mem_b_ready_o,
    .beat_strobe_o(beat_strobe), .beat_is_b_o(beat_is_b), .beat_row_o(beat_row),
    .feed_start_o(feed_start), .results_ready_i(results_ready), .wr_go_o(wr_go)
  );

  mxu_operand_feeder operand_feeder_inst (
    .ap_clk, .ap_rst_n, .beat_strobe_i(beat_strobe), .beat_is_b_i(beat_is_b),
    .beat_row_i(beat_row), .feed_start_i(feed_start),
    .west_elem_o(west_elem), .west_valid_o(west_valid),
    .north_elem_o(north_elem), .north_valid_o(north_valid),
    .acc_clear_o(acc_clear), .capture_o(capture)
  );

  mxu_result_drain result_drain_inst (
    .ap_clk, .ap_rst_n, .capture_i(capture), .acc_i(acc_all),
    .results_ready_o(results_ready), .wr_go_i(wr_go),
    .mem_w_valid_o, .mem_w_o, .mem_w_ready_i
  );

  for (genvar i = 0; i < ARRAY_N; i++) begin : g_row
    // grid edges fed by the feeder
    assign h_elem[i][0]  = west_elem[i];
    assign h_valid[i][0] = west_valid[i];
    assign v_elem[0][i]  = north_elem[i];
    assign v_valid[0][i] = north_valid[i];
    for (genvar j = 0; j < ARRAY_N; j++) begin : g_col
      mxu_pe pe_inst (
        .ap_clk, .ap_rst_n, .acc_clear_i(acc_clear),
        .west_elem_i(h_elem[i][j]), .west_valid_i(h_valid[i][j]),
        .north_elem_i(v_elem[i][j]), .north_valid_i(v_valid[i][j]),
        .east_elem_o(h_elem[i][j+1]), .east_valid_o(h_valid[i][j+1]),
        .south_elem_o(v_elem[i+1][j]), .south_valid_o(v_valid[i+1][j]),
        .acc_o(acc_all[i*ARRAY_N+j])
      );
    end
  end

endmodule
